// ==== Makefile ====
SIM      := verilator
FLAGS    := --binary --timing -Wno-fatal
TOP      := tb_dft5
FILELIST := tb.f

BUILD    := obj_dir
LOG      := sim.log
SOURCES  := $(shell grep -v '^+' $(FILELIST))
BIN      := $(BUILD)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "Verification passed" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== logic/dft5_emit_ctrl.sv ====
`timescale 1ns/1ps

module dft5_emit_ctrl import dft5_pkg::*; (
	input  logic clk,
	input  logic rst_n,
	input  logic bfly_val,
	input  logic emit_wrap,
	output logic buf_load,
	output logic emit_en,
	output logic out_val,
	output logic out_last
);

	emit_state_e state;
	emit_state_e state_nxt;

	logic running;

	assign running = (state == EMIT_RUN);

	// a new frame is taken when idle or right as the last result leaves
	assign buf_load = bfly_val && (!running || emit_wrap);

	assign emit_en  = running;
	assign out_val  = running;
	assign out_last = emit_wrap;

	always_comb begin
		state_nxt = state;
		case (state)
			EMIT_IDLE: begin
				if (bfly_val) begin
					state_nxt = EMIT_RUN;
				end
			end
			EMIT_RUN: begin
				// back-to-back frames keep the FSM in run
				if (emit_wrap && !bfly_val) begin
					state_nxt = EMIT_IDLE;
				end
			end
			default: begin
				state_nxt = EMIT_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= EMIT_IDLE;
		end else begin
			state <= state_nxt;
		end
	end

endmodule

// ==== logic/dft5_engine.sv ====
`timescale 1ns/1ps

module dft5_engine import dft5_pkg::*; #(
	parameter int data_w = 30
) (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     in_val,
	input  logic signed [data_w-1:0] in_real,
	input  logic signed [data_w-1:0] in_imag,
	output logic                     out_val,
	output logic signed [data_w-1:0] out_real,
	output logic signed [data_w-1:0] out_imag,
	output logic [idx_w-1:0]         out_idx,
	output logic                     out_last
);

	logic             in_wrap;
	logic             frame_val;
	logic             bfly_val;
	logic             buf_load;
	logic             emit_en;
	logic             emit_wrap;

	logic signed [data_w-1:0] frm_real [0:frame_len-1];
	logic signed [data_w-1:0] frm_imag [0:frame_len-1];
	logic signed [data_w-1:0] res_real [0:frame_len-1];
	logic signed [data_w-1:0] res_imag [0:frame_len-1];

	// wrap pulse marks the fifth sample of a frame
	dft5_index_counter #(.modulus(frame_len)) u_in_cnt (
		.clk  (clk),
		.rst_n(rst_n),
		.en   (in_val),
		.idx  (),
		.wrap (in_wrap)
	);

	dft5_input_gather #(.data_w(data_w)) u_gather (
		.clk      (clk),
		.rst_n    (rst_n),
		.in_val   (in_val),
		.in_real  (in_real),
		.in_imag  (in_imag),
		.last     (in_wrap),
		.frame_val(frame_val),
		.frm_real (frm_real),
		.frm_imag (frm_imag)
	);

	mrd_dft_rdx5 #(.data_w(data_w)) u_bfly (
		.clk      (clk),
		.rst_n    (rst_n),
		.in_val   (frame_val),
		.din_real (frm_real),
		.din_imag (frm_imag),
		.out_val  (bfly_val),
		.dout_real(res_real),
		.dout_imag(res_imag)
	);

	dft5_emit_ctrl u_emit (
		.clk      (clk),
		.rst_n    (rst_n),
		.bfly_val (bfly_val),
		.emit_wrap(emit_wrap),
		.buf_load (buf_load),
		.emit_en  (emit_en),
		.out_val  (out_val),
		.out_last (out_last)
	);

	dft5_index_counter #(.modulus(frame_len)) u_out_cnt (
		.clk  (clk),
		.rst_n(rst_n),
		.en   (emit_en),
		.idx  (out_idx),
		.wrap (emit_wrap)
	);

	dft5_output_buffer #(.data_w(data_w)) u_obuf (
		.clk     (clk),
		.rst_n   (rst_n),
		.buf_load(buf_load),
		.sel     (out_idx),
		.res_real(res_real),
		.res_imag(res_imag),
		.out_real(out_real),
		.out_imag(out_imag)
	);

endmodule

// ==== logic/dft5_index_counter.sv ====
`timescale 1ns/1ps

module dft5_index_counter import dft5_pkg::*; #(
	parameter int modulus = frame_len
) (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             en,
	output logic [idx_w-1:0] idx,
	output logic             wrap
);

	logic at_last;

	assign at_last = (idx == idx_w'(modulus - 1));

	// wrap flags the enabled cycle at the top index
	assign wrap = en && at_last;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			idx <= '0;
		end else if (en) begin
			if (at_last) begin
				idx <= '0;
			end else begin
				idx <= idx + 1'b1;
			end
		end
	end

endmodule

// ==== logic/dft5_input_gather.sv ====
`timescale 1ns/1ps

module dft5_input_gather import dft5_pkg::*; #(
	parameter int data_w = 30
) (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     in_val,
	input  logic signed [data_w-1:0] in_real,
	input  logic signed [data_w-1:0] in_imag,
	input  logic                     last,
	output logic                     frame_val,
	output logic signed [data_w-1:0] frm_real [0:frame_len-1],
	output logic signed [data_w-1:0] frm_imag [0:frame_len-1]
);

	// earlier samples of the frame, oldest in entry 0
	// the incoming sample forms the fifth entry
	logic signed [data_w-1:0] line_real [0:frame_len-2];
	logic signed [data_w-1:0] line_imag [0:frame_len-2];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int k = 0; k < frame_len - 1; k++) begin
				line_real[k] <= '0;
				line_imag[k] <= '0;
			end
		end else if (in_val) begin
			for (int k = 0; k < frame_len - 2; k++) begin
				line_real[k] <= line_real[k+1];
				line_imag[k] <= line_imag[k+1];
			end
			line_real[frame_len-2] <= in_real;
			line_imag[frame_len-2] <= in_imag;
		end
	end

	// frame is held here until the next one completes
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			frame_val <= 1'b0;
			for (int k = 0; k < frame_len; k++) begin
				frm_real[k] <= '0;
				frm_imag[k] <= '0;
			end
		end else begin
			frame_val <= in_val && last;
			if (in_val && last) begin
				for (int k = 0; k < frame_len - 1; k++) begin
					frm_real[k] <= line_real[k];
					frm_imag[k] <= line_imag[k];
				end
				frm_real[frame_len-1] <= in_real;
				frm_imag[frame_len-1] <= in_imag;
			end
		end
	end

endmodule

// ==== logic/dft5_output_buffer.sv ====
`timescale 1ns/1ps

module dft5_output_buffer import dft5_pkg::*; #(
	parameter int data_w = 30
) (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     buf_load,
	input  logic [idx_w-1:0]         sel,
	input  logic signed [data_w-1:0] res_real [0:frame_len-1],
	input  logic signed [data_w-1:0] res_imag [0:frame_len-1],
	output logic signed [data_w-1:0] out_real,
	output logic signed [data_w-1:0] out_imag
);

	logic signed [data_w-1:0] mem_real [0:frame_len-1];
	logic signed [data_w-1:0] mem_imag [0:frame_len-1];

	// one frame of butterfly results
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int k = 0; k < frame_len; k++) begin
				mem_real[k] <= '0;
				mem_imag[k] <= '0;
			end
		end else if (buf_load) begin
			for (int k = 0; k < frame_len; k++) begin
				mem_real[k] <= res_real[k];
				mem_imag[k] <= res_imag[k];
			end
		end
	end

	// unused select codes read as zero
	always_comb begin
		out_real = '0;
		out_imag = '0;
		if (sel < idx_w'(frame_len)) begin
			out_real = mem_real[sel];
			out_imag = mem_imag[sel];
		end
	end

endmodule

// ==== logic/dft5_pkg.sv ====
package dft5_pkg;

	// points per radix-5 frame
	localparam int frame_len = 5;

	// wide enough for indices 0 to frame_len-1
	localparam int idx_w = 3;

	// constants are Q14, so products shift back down by 14
	localparam int tw_shift = 14;

	// product register width in the butterfly
	localparam int prod_w = 48;

	// 0.559 = (cos(2pi/5) - cos(4pi/5)) / 2
	localparam logic signed [17:0] k_c3 = 18'sd9159;

	// 1.539
	localparam logic signed [17:0] k_c4 = 18'sd25215;

	// 0.362
	localparam logic signed [17:0] k_c5 = 18'sd5931;

	// 0.951 = sin(2pi/5)
	localparam logic signed [17:0] k_c6 = 18'sd15581;

	typedef enum logic {
		EMIT_IDLE,
		EMIT_RUN
	} emit_state_e;

endpackage

// ==== logic/mrd_dft_rdx5.sv ====
`timescale 1ns/1ps

module mrd_dft_rdx5 import dft5_pkg::*; #(
	parameter int data_w = 30
) (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     in_val,
	input  logic signed [data_w-1:0] din_real [0:frame_len-1],
	input  logic signed [data_w-1:0] din_imag [0:frame_len-1],
	output logic                     out_val,
	output logic signed [data_w-1:0] dout_real [0:frame_len-1],
	output logic signed [data_w-1:0] dout_imag [0:frame_len-1]
);

	logic [1:0] val_r;

	// symmetric pairs x1/x4 and x2/x3
	logic signed [data_w-1:0] a_re, a_im, b_re, b_im;
	logic signed [data_w-1:0] c_re, c_im, d_re, d_im;

	logic signed [data_w-1:0] p1_re [1:6];
	logic signed [data_w-1:0] p1_im [1:6];
	logic signed [prod_w-1:0] p2_re [1:6];
	logic signed [prod_w-1:0] p2_im [1:6];

	// stage 2 terms back at data_w
	logic signed [data_w-1:0] t2_re [1:6];
	logic signed [data_w-1:0] t2_im [1:6];

	logic signed [data_w-1:0] m_re [1:4];
	logic signed [data_w-1:0] m_im [1:4];

	assign a_re = din_real[1] + din_real[4];
	assign a_im = din_imag[1] + din_imag[4];
	assign b_re = din_real[2] + din_real[3];
	assign b_im = din_imag[2] + din_imag[3];
	assign c_re = din_real[1] - din_real[4];
	assign c_im = din_imag[1] - din_imag[4];
	assign d_re = din_real[2] - din_real[3];
	assign d_im = din_imag[2] - din_imag[3];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int k = 1; k <= 6; k++) begin
				p1_re[k] <= '0;
				p1_im[k] <= '0;
				p2_re[k] <= '0;
				p2_im[k] <= '0;
			end
		end else begin
			// stage 1
			p1_re[1] <= din_real[0];
			p1_im[1] <= din_imag[0];
			p1_re[2] <= a_re + b_re;
			p1_im[2] <= a_im + b_im;
			p1_re[3] <= a_re - b_re;
			p1_im[3] <= a_im - b_im;
			p1_re[4] <= c_re;
			p1_im[4] <= c_im;
			p1_re[5] <= d_re;
			p1_im[5] <= d_im;
			p1_re[6] <= c_re + d_re;
			p1_im[6] <= c_im + d_im;

			// stage 2, X0 and x0 minus a quarter of the sum
			p2_re[1] <= p1_re[1] + p1_re[2];
			p2_im[1] <= p1_im[1] + p1_im[2];
			p2_re[2] <= p1_re[1] - (p1_re[2] >>> 2);
			p2_im[2] <= p1_im[1] - (p1_im[2] >>> 2);

			p2_re[3] <= p1_re[3] * k_c3;
			p2_im[3] <= p1_im[3] * k_c3;

			// multiplied by -j, real and imaginary swap
			p2_re[4] <= p1_im[4] * k_c4;
			p2_im[4] <= p1_re[4] * -k_c4;
			p2_re[5] <= p1_im[5] * k_c5;
			p2_im[5] <= p1_re[5] * -k_c5;
			p2_re[6] <= p1_im[6] * -k_c6;
			p2_im[6] <= p1_re[6] * k_c6;
		end
	end

	assign t2_re[1] = data_w'(p2_re[1]);
	assign t2_im[1] = data_w'(p2_im[1]);
	assign t2_re[2] = data_w'(p2_re[2]);
	assign t2_im[2] = data_w'(p2_im[2]);

	for (genvar g = 3; g <= 6; g++) begin : g_scale
		assign t2_re[g] = data_w'(p2_re[g] >>> tw_shift);
		assign t2_im[g] = data_w'(p2_im[g] >>> tw_shift);
	end

	assign m_re[1] = t2_re[2] + t2_re[3];
	assign m_im[1] = t2_im[2] + t2_im[3];
	assign m_re[2] = t2_re[5] + t2_re[6];
	assign m_im[2] = t2_im[5] + t2_im[6];
	assign m_re[3] = t2_re[2] - t2_re[3];
	assign m_im[3] = t2_im[2] - t2_im[3];
	assign m_re[4] = t2_re[4] + t2_re[6];
	assign m_im[4] = t2_im[4] + t2_im[6];

	// stage 3 and the valid pipe
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			val_r   <= '0;
			out_val <= 1'b0;
			for (int k = 0; k < frame_len; k++) begin
				dout_real[k] <= '0;
				dout_imag[k] <= '0;
			end
		end else begin
			val_r   <= {val_r[0], in_val};
			out_val <= val_r[1];

			dout_real[0] <= t2_re[1];
			dout_imag[0] <= t2_im[1];
			dout_real[1] <= m_re[1] - m_re[2];
			dout_imag[1] <= m_im[1] - m_im[2];
			dout_real[2] <= m_re[3] + m_re[4];
			dout_imag[2] <= m_im[3] + m_im[4];
			dout_real[3] <= m_re[3] - m_re[4];
			dout_imag[3] <= m_im[3] - m_im[4];
			dout_real[4] <= m_re[1] + m_re[2];
			dout_imag[4] <= m_im[1] + m_im[2];
		end
	end

endmodule

// ==== tb.f ====
logic/dft5_pkg.sv
logic/dft5_index_counter.sv
logic/dft5_input_gather.sv
logic/mrd_dft_rdx5.sv
logic/dft5_emit_ctrl.sv
logic/dft5_output_buffer.sv
logic/dft5_engine.sv
tests/dft5_checker.sv
tests/tb_dft5.sv

// ==== tests/dft5_checker.sv ====
`timescale 1ns/1ps

module dft5_checker import dft5_pkg::*; #(
	parameter int data_w = 30
) (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     in_val,
	input  logic signed [data_w-1:0] in_real,
	input  logic signed [data_w-1:0] in_imag,
	input  logic                     out_val,
	input  logic signed [data_w-1:0] out_real,
	input  logic signed [data_w-1:0] out_imag,
	input  logic [idx_w-1:0]         out_idx,
	input  logic                     out_last,
	output int                       errors,
	output int                       frames_in,
	output int                       frames_out,
	output int                       pending
);

	// samples of the frame being collected, oldest first
	longint col_re [0:frame_len-1];
	longint col_im [0:frame_len-1];
	int     fill;
	int     slot;
	longint cycle = 0;

	// expected results in emission order and the edge each one is due at
	longint exp_re_q [$];
	longint exp_im_q [$];
	longint due_q [$];

	// keep the low w bits, sign-extended
	function automatic longint fit(input longint v, input int w);
		return (v <<< (64 - w)) >>> (64 - w);
	endfunction

	// Q14 constant multiply, product held at prod_w
	function automatic longint scale(input longint v, input longint k);
		return fit(fit(v * k, prod_w) >>> tw_shift, data_w);
	endfunction

	// one component of DFT point n, part 0 real and 1 imaginary
	function automatic longint dft_point(input int n, input int part);
		longint x [0:frame_len-1];
		longint y [0:frame_len-1];
		longint a, b, c, d, sum, q, r3, r4, r5, r6, m1, m2, m3, m4, res;
		longint sgn;
		for (int k = 0; k < frame_len; k++) begin
			x[k] = (part == 0) ? col_re[k] : col_im[k];
			y[k] = (part == 0) ? col_im[k] : col_re[k];
		end
		// -j rotation reads the other component, negated on the imaginary side
		sgn = (part == 0) ? 1 : -1;
		a = fit(x[1] + x[4], data_w);
		b = fit(x[2] + x[3], data_w);
		c = fit(y[1] - y[4], data_w);
		d = fit(y[2] - y[3], data_w);
		sum = fit(a + b, data_w);
		q = fit(x[0] - (sum >>> 2), data_w);
		r3 = scale(fit(a - b, data_w), k_c3);
		r4 = scale(c, sgn * k_c4);
		r5 = scale(d, sgn * k_c5);
		r6 = scale(fit(c + d, data_w), -sgn * k_c6);
		m1 = fit(q + r3, data_w);
		m2 = fit(r5 + r6, data_w);
		m3 = fit(q - r3, data_w);
		m4 = fit(r4 + r6, data_w);
		case (n)
			0: res = x[0] + sum;
			1: res = m1 - m2;
			2: res = m3 + m4;
			3: res = m3 - m4;
			default: res = m1 + m2;
		endcase
		return fit(res, data_w);
	endfunction

	task automatic report_value(input string name, input longint exp, input longint act);
		if (exp != act) begin
			$display("FAILED at %0t: %s expected %0d, got %0d", $time, name, exp, act);
			errors++;
		end
	endtask

	task automatic check_outputs();
		if (!out_val) begin
			if (out_last) begin
				$display("ERROR at %0t: out_last is high while out_val is low", $time);
				errors++;
			end
			// nothing loaded yet, so the buffer still reads zero
			if (frames_out == 0) begin
				report_value("out_real", 0, out_real);
				report_value("out_imag", 0, out_imag);
			end
			if (due_q.size() > 0 && due_q[0] <= cycle) begin
				$display("ERROR at %0t: out_val stayed low when result %0d was due", $time, slot);
				errors++;
			end else begin
				return;
			end
		end else if (due_q.size() == 0) begin
			$display("ERROR at %0t: out_val is high but no result is expected", $time);
			errors++;
			return;
		end else begin
			if (due_q[0] != cycle) begin
				$display("ERROR at %0t: result %0d came %0d cycles off its slot", $time, slot,
					cycle - due_q[0]);
				errors++;
			end
			report_value("out_idx", slot, out_idx);
			report_value("out_last", slot == frame_len - 1, out_last);
			report_value("out_real", exp_re_q[0], out_real);
			report_value("out_imag", exp_im_q[0], out_imag);
			if (slot == frame_len - 1) begin
				frames_out++;
			end
		end
		void'(exp_re_q.pop_front());
		void'(exp_im_q.pop_front());
		void'(due_q.pop_front());
		slot = (slot == frame_len - 1) ? 0 : slot + 1;
	endtask

	always @(posedge clk) begin
		cycle++;
		if (!rst_n) begin
			fill = 0;
			slot = 0;
			errors = 0;
			frames_in = 0;
			frames_out = 0;
			exp_re_q.delete();
			exp_im_q.delete();
			due_q.delete();
		end else begin
			check_outputs();
			if (in_val) begin
				col_re[fill] = in_real;
				col_im[fill] = in_imag;
				fill++;
				// results leave five edges after the fifth sample
				if (fill == frame_len) begin
					fill = 0;
					frames_in++;
					for (int n = 0; n < frame_len; n++) begin
						exp_re_q.push_back(dft_point(n, 0));
						exp_im_q.push_back(dft_point(n, 1));
						due_q.push_back(cycle + 5 + n);
					end
				end
			end
		end
		pending = due_q.size();
	end

endmodule

// ==== tests/tb_dft5.sv ====
`timescale 1ns/1ps

module tb_dft5 import dft5_pkg::*; ();

	localparam int data_w = 30;
	localparam int drain_limit = 200;

	logic                     clk;
	logic                     rst_n;
	logic                     in_val;
	logic signed [data_w-1:0] in_real;
	logic signed [data_w-1:0] in_imag;
	logic                     out_val;
	logic signed [data_w-1:0] out_real;
	logic signed [data_w-1:0] out_imag;
	logic [idx_w-1:0]         out_idx;
	logic                     out_last;
	int                       errors;
	int                       frames_in;
	int                       frames_out;
	int                       pending;
	logic [31:0]              lfsr;
	bit                       timed_out;

	always #4 clk = ~clk;

	dft5_engine #(.data_w(data_w)) u_dut (
		.clk     (clk),
		.rst_n   (rst_n),
		.in_val  (in_val),
		.in_real (in_real),
		.in_imag (in_imag),
		.out_val (out_val),
		.out_real(out_real),
		.out_imag(out_imag),
		.out_idx (out_idx),
		.out_last(out_last)
	);

	dft5_checker #(.data_w(data_w)) u_chk (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_val    (in_val),
		.in_real   (in_real),
		.in_imag   (in_imag),
		.out_val   (out_val),
		.out_real  (out_real),
		.out_imag  (out_imag),
		.out_idx   (out_idx),
		.out_last  (out_last),
		.errors    (errors),
		.frames_in (frames_in),
		.frames_out(frames_out),
		.pending   (pending)
	);

	// Galois form of x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 32'h80200003;
		end
		return s >> 1;
	endfunction

	task automatic draw(input int nbits, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < nbits; i++) begin
			lfsr = lfsr_next(lfsr);
			v = {v[30:0], lfsr[0]};
		end
	endtask

	task automatic drive(input logic val, input longint re, input longint im);
		@(negedge clk);
		in_val = val;
		in_real = data_w'(re);
		in_imag = data_w'(im);
	endtask

	// samples stay within +-2^24
	task automatic send_random_frames(input int frames, input bit gaps);
		logic [31:0] v;
		longint re;
		longint im;
		int sent;
		sent = 0;
		while (sent < frames * frame_len) begin
			v = 32'd1;
			if (gaps) begin
				draw(1, v);
			end
			if (v[0]) begin
				draw(25, v);
				re = $signed(v[24:0]);
				draw(25, v);
				im = $signed(v[24:0]);
				drive(1'b1, re, im);
				sent++;
			end else begin
				drive(1'b0, 0, 0);
			end
		end
		drive(1'b0, 0, 0);
	endtask

	task automatic wait_drain();
		int n;
		n = 0;
		while (pending != 0 && n < drain_limit) begin
			@(negedge clk);
			n++;
		end
		if (pending != 0) begin
			$display("timeout: %0d results still outstanding after %0d cycles", pending, n);
			timed_out = 1'b1;
		end
	endtask

	// directed frames, then back-to-back and gapped random frames
	task automatic run_sequence();
		repeat (4) drive(1'b0, 0, 0);
		// DC frame, then an impulse in x0
		repeat (frame_len) drive(1'b1, 1000, -300);
		drive(1'b0, 0, 0);
		wait_drain();
		if (timed_out) begin
			return;
		end
		drive(1'b1, 77777, -4321);
		repeat (frame_len - 1) drive(1'b1, 0, 0);
		drive(1'b0, 0, 0);
		wait_drain();
		if (timed_out) begin
			return;
		end
		send_random_frames(20, 1'b0);
		wait_drain();
		if (timed_out) begin
			return;
		end
		send_random_frames(20, 1'b1);
		wait_drain();
	endtask

	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		in_val = 1'b0;
		in_real = '0;
		in_imag = '0;
		lfsr = 32'd87;
		timed_out = 1'b0;
		repeat (16) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		run_sequence();
		if (!timed_out) begin
			repeat (8) @(negedge clk);
		end
		$display("errors: %0d, input frames: %0d, output frames: %0d", errors, frames_in,
			frames_out);
		if (!timed_out && errors == 0 && frames_in == frames_out && frames_in > 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule
